// File: Makefile
# Verilator build and run of the write-through data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_wt_dcache
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Simulation passed

SOURCES := $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, look for the pass message"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: src/cache_wr_if.sv
// single word write into the cache array
// no back-pressure, the write happens in the valid cycle

`timescale 1ns/1ns

interface cache_wr_if;

  logic           valid;
  dc_pkg::addr_t  addr;
  mem_pkg::word_t wdata;
  mem_pkg::be_t   be;

  modport writer (
    output valid, addr, wdata, be
  );

  modport array (
    input valid, addr, wdata, be
  );

endinterface

// File: src/dc_defines.svh
// L1 data cache sizing
// widths of address and data, number of lines, write buffer depth

`ifndef DC_DEFINES_SVH
`define DC_DEFINES_SVH

// byte address and data word
`define DC_ADDR_W 32
`define DC_DATA_W 32

// 16 direct-mapped lines of one word
`define DC_INDEX_W 4

// store entries in flight toward memory
`define DC_WBUF_DEPTH 4

`endif

// File: src/dc_load_ctrl.sv
// load controller
// array lookup, hit return one cycle after accept, miss read otherwise

`timescale 1ns/1ns

module dc_load_ctrl (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           ld_req_i,
  input  dc_pkg::addr_t  ld_addr_i,
  output logic           ld_gnt_o,
  output logic           ld_rvalid_o,
  output mem_pkg::word_t ld_rdata_o,
  input  logic           cache_en_i,
  output dc_pkg::index_t lookup_idx_o,
  input  dc_pkg::line_t  lookup_line_i,
  output logic           miss_o,
  dc_port_if.client      miss,
  output logic           busy_o
);

  typedef enum logic [1:0] {IDLE, LOOKUP, WAIT_MISS} state_e;

  state_e        state_q;
  logic          req_q;
  dc_pkg::addr_t addr_q;
  logic          hit;

  // the array registers this index on the accepting edge
  assign lookup_idx_o = dc_pkg::addr_index(ld_addr_i);

  assign ld_gnt_o = (state_q == IDLE) && ld_req_i;
  assign busy_o   = (state_q != IDLE);

  assign hit = lookup_line_i.valid && cache_en_i &&
               (lookup_line_i.tag == dc_pkg::addr_tag(addr_q));

  assign miss_o      = (state_q == LOOKUP) && !hit;
  assign ld_rvalid_o = ((state_q == LOOKUP) && hit) ||
                       ((state_q == WAIT_MISS) && miss.rvalid);
  assign ld_rdata_o  = (state_q == LOOKUP) ? lookup_line_i.data : miss.rdata;

  // word read toward memory
  assign miss.req   = req_q;
  assign miss.we    = 1'b0;
  assign miss.addr  = addr_q;
  assign miss.wdata = '0;
  assign miss.be    = '1;

  always_ff @(posedge clk_i) begin
    if (ld_gnt_o) begin
      addr_q <= ld_addr_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      req_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (ld_gnt_o) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (hit) begin
            state_q <= IDLE;
          end else begin
            state_q <= WAIT_MISS;
            req_q   <= 1'b1;
          end
        end
        WAIT_MISS: begin
          if (miss.gnt) begin
            req_q <= 1'b0;
          end
          if (miss.rvalid) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// File: src/dc_mem.sv
// cache array: valid bits, tags and data words
// registered lookup, refill and store-update write ports, invalidate-all

`timescale 1ns/1ns
`include "dc_defines.svh"

module dc_mem (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  dc_pkg::index_t    lookup_idx_i,
  output dc_pkg::line_t     lookup_line_o,
  cache_wr_if.array         refill,
  cache_wr_if.array         store_upd,
  input  logic              inval_all_i
);

  localparam int unsigned NUM_LINES = 1 << `DC_INDEX_W;

  logic [NUM_LINES-1:0] valid_q;
  dc_pkg::tag_t         tag_q  [NUM_LINES];
  mem_pkg::word_t       data_q [NUM_LINES];

  dc_pkg::index_t fill_idx;
  dc_pkg::index_t upd_idx;
  logic           upd_hit;
  logic           same_word;
  mem_pkg::word_t fill_word;
  mem_pkg::word_t upd_word;

  function automatic mem_pkg::word_t merge(mem_pkg::word_t old_w, mem_pkg::word_t new_w,
                                           mem_pkg::be_t be);
    mem_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < $bits(be); b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign fill_idx = dc_pkg::addr_index(refill.addr);
  assign upd_idx  = dc_pkg::addr_index(store_upd.addr);

  // store only touches a line that already holds its address
  assign upd_hit = store_upd.valid && valid_q[upd_idx] &&
                   (tag_q[upd_idx] == dc_pkg::addr_tag(store_upd.addr));

  // a store landing with the refill of its word is folded into the refill
  assign same_word = store_upd.valid && refill.valid && (store_upd.addr == refill.addr);

  always_comb begin
    fill_word = merge(data_q[fill_idx], refill.wdata, refill.be);
    if (same_word) begin
      fill_word = merge(fill_word, store_upd.wdata, store_upd.be);
    end
    upd_word = merge(data_q[upd_idx], store_upd.wdata, store_upd.be);
  end

  always_ff @(posedge clk_i) begin
    lookup_line_o <= '{valid: valid_q[lookup_idx_i],
                       tag:   tag_q[lookup_idx_i],
                       data:  data_q[lookup_idx_i]};
    if (refill.valid) begin
      tag_q[fill_idx]  <= dc_pkg::addr_tag(refill.addr);
      data_q[fill_idx] <= fill_word;
    end
    if (upd_hit && !(refill.valid && fill_idx == upd_idx)) begin
      data_q[upd_idx] <= upd_word;
    end
  end

  // invalidate wins over a refill in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else begin
      if (refill.valid) begin
        valid_q[fill_idx] <= 1'b1;
      end
      if (inval_all_i) begin
        valid_q <= '0;
      end
    end
  end

endmodule

// File: src/dc_miss_unit.sv
// miss unit: memory arbiter, refill, cache enable and flush handshake
// buffered writes go first, a load read only with the buffer drained

`timescale 1ns/1ns

module dc_miss_unit (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           enable_i,
  input  logic           flush_i,
  output logic           flush_ack_o,
  output logic           cache_en_o,
  dc_port_if.unit        ld,
  dc_port_if.unit        st,
  input  logic           wbuf_empty_i,
  input  logic           ld_busy_i,
  cache_wr_if.writer     refill,
  output logic           inval_all_o,
  output logic           mem_req_o,
  input  logic           mem_gnt_i,
  output logic           mem_we_o,
  output dc_pkg::addr_t  mem_addr_o,
  output mem_pkg::word_t mem_wdata_o,
  output mem_pkg::be_t   mem_be_o,
  input  logic           mem_rvalid_i,
  input  mem_pkg::word_t mem_rdata_i
);

  logic          cache_en_q;
  logic          flush_done_q;
  logic          rd_pend_q;
  logic          lock_q;
  logic          lock_rd_q;
  dc_pkg::addr_t rd_addr_q;
  logic          sel_rd;
  logic          rd_ok;

  ////////////////////////////////////////////////////////////
  // memory arbitration
  ////////////////////////////////////////////////////////////

  assign rd_ok = ld.req && wbuf_empty_i && !st.req;

  // an offered request holds its choice until granted
  always_comb begin
    if (lock_q) begin
      sel_rd    = lock_rd_q;
      mem_req_o = 1'b1;
    end else begin
      sel_rd    = !st.req;
      mem_req_o = !rd_pend_q && (st.req || rd_ok);
    end
  end

  assign mem_we_o    = sel_rd ? ld.we    : st.we;
  assign mem_addr_o  = sel_rd ? ld.addr  : st.addr;
  assign mem_wdata_o = sel_rd ? ld.wdata : st.wdata;
  assign mem_be_o    = sel_rd ? ld.be    : st.be;

  assign ld.gnt = mem_req_o && mem_gnt_i && sel_rd;
  assign st.gnt = mem_req_o && mem_gnt_i && !sel_rd;

  // writes get no response
  assign st.rvalid = 1'b0;
  assign st.rdata  = '0;

  assign ld.rvalid = rd_pend_q && mem_rvalid_i;
  assign ld.rdata  = mem_rdata_i;

  // no refill once a younger store sits in the buffer
  assign refill.valid = ld.rvalid && cache_en_q && wbuf_empty_i;
  assign refill.addr  = rd_addr_q;
  assign refill.wdata = mem_rdata_i;
  assign refill.be    = '1;

  ////////////////////////////////////////////////////////////
  // enable and flush
  ////////////////////////////////////////////////////////////

  assign cache_en_o  = cache_en_q;
  assign flush_ack_o = flush_i && !flush_done_q && wbuf_empty_i && !ld_busy_i;
  // disabling the cache also drops every line
  assign inval_all_o = flush_ack_o || (cache_en_q && !enable_i);

  always_ff @(posedge clk_i) begin
    if (ld.gnt) begin
      rd_addr_q <= ld.addr;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cache_en_q   <= 1'b0;
      flush_done_q <= 1'b0;
      rd_pend_q    <= 1'b0;
      lock_q       <= 1'b0;
      lock_rd_q    <= 1'b0;
    end else begin
      cache_en_q   <= enable_i;
      flush_done_q <= flush_i && (flush_done_q || flush_ack_o);
      lock_q       <= mem_req_o && !mem_gnt_i;
      lock_rd_q    <= sel_rd;
      if (ld.gnt) begin
        rd_pend_q <= 1'b1;
      end else if (mem_rvalid_i) begin
        rd_pend_q <= 1'b0;
      end
    end
  end

endmodule

// File: src/dc_pkg.sv
// L1 data cache types
// address split into tag, index and byte offset, and the line entry

`include "dc_defines.svh"

package dc_pkg;

  localparam int unsigned OFFSET_W = $clog2(`DC_DATA_W / 8);
  localparam int unsigned TAG_W    = `DC_ADDR_W - `DC_INDEX_W - OFFSET_W;

  typedef logic [`DC_ADDR_W-1:0]  addr_t;
  typedef logic [`DC_INDEX_W-1:0] index_t;
  typedef logic [TAG_W-1:0]       tag_t;

  // one cache line holds a single word
  typedef struct packed {
    logic                 valid;
    tag_t                 tag;
    logic [`DC_DATA_W-1:0] data;
  } line_t;

  function automatic index_t addr_index(addr_t addr);
    return addr[OFFSET_W +: `DC_INDEX_W];
  endfunction

  function automatic tag_t addr_tag(addr_t addr);
    return addr[`DC_ADDR_W-1 -: TAG_W];
  endfunction

endpackage

// File: src/dc_port_if.sv
// request/response port between a cache client and the miss unit
// transfer on req & gnt, reads answered later by one rvalid pulse

`timescale 1ns/1ns

interface dc_port_if;

  logic          req;
  logic          gnt;
  logic          we;
  dc_pkg::addr_t addr;
  mem_pkg::word_t wdata;
  mem_pkg::be_t  be;
  logic          rvalid;
  mem_pkg::word_t rdata;

  modport client (
    output req, we, addr, wdata, be,
    input  gnt, rvalid, rdata
  );

  modport unit (
    input  req, we, addr, wdata, be,
    output gnt, rvalid, rdata
  );

endinterface

// File: src/dc_wbuffer.sv
// in-order write buffer on the store path
// updates the cache on accept, drains to memory oldest first

`timescale 1ns/1ns
`include "dc_defines.svh"

module dc_wbuffer (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           st_req_i,
  input  dc_pkg::addr_t  st_addr_i,
  input  mem_pkg::word_t st_wdata_i,
  input  mem_pkg::be_t   st_be_i,
  output logic           st_gnt_o,
  cache_wr_if.writer     store_upd,
  dc_port_if.client      mem,
  output logic           empty_o
);

  localparam int unsigned DEPTH = `DC_WBUF_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  mem_pkg::mem_req_t         fifo_q [DEPTH];
  logic [PTR_W-1:0]          wr_ptr_q;
  logic [PTR_W-1:0]          rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;
  logic                      push;
  logic                      pop;
  mem_pkg::mem_req_t         head;

  assign st_gnt_o = (count_q != DEPTH);
  assign empty_o  = (count_q == '0);
  assign push     = st_req_i && st_gnt_o;
  assign pop      = mem.req && mem.gnt;

  // cache update in the accepting cycle, the array checks for a hit
  assign store_upd.valid = push;
  assign store_upd.addr  = st_addr_i;
  assign store_upd.wdata = st_wdata_i;
  assign store_upd.be    = st_be_i;

  ////////////////////////////////////////////////////////////
  // head of queue toward memory
  ////////////////////////////////////////////////////////////

  assign head      = fifo_q[rd_ptr_q];
  assign mem.req   = !empty_o;
  assign mem.we    = head.we;
  assign mem.addr  = head.addr;
  assign mem.wdata = head.wdata;
  assign mem.be    = head.be;

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= '{we: 1'b1, addr: st_addr_i, wdata: st_wdata_i, be: st_be_i};
    end
  end

  // pointers wrap at the power-of-two depth
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + push - pop;
    end
  end

endmodule

// File: src/mem_pkg.sv
// memory side types
// data word, byte enables and one buffered memory request

`include "dc_defines.svh"

package mem_pkg;

  typedef logic [`DC_DATA_W-1:0]   word_t;
  typedef logic [`DC_DATA_W/8-1:0] be_t;

  // entry of the store queue, also the shape of a memory request
  typedef struct packed {
    logic          we;
    dc_pkg::addr_t addr;
    word_t         wdata;
    be_t           be;
  } mem_req_t;

endpackage

// File: src/wt_dcache.sv
// write-through direct-mapped L1 data cache
// load and store ports toward the core, one memory port, flush and enable

`timescale 1ns/1ns

module wt_dcache (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           enable_i,
  input  logic           flush_i,
  output logic           flush_ack_o,
  output logic           miss_o,
  output logic           wbuffer_empty_o,
  // load port
  input  logic           ld_req_i,
  output logic           ld_gnt_o,
  input  dc_pkg::addr_t  ld_addr_i,
  output logic           ld_rvalid_o,
  output mem_pkg::word_t ld_rdata_o,
  // store port
  input  logic           st_req_i,
  output logic           st_gnt_o,
  input  dc_pkg::addr_t  st_addr_i,
  input  mem_pkg::word_t st_wdata_i,
  input  mem_pkg::be_t   st_be_i,
  // memory
  output logic           mem_req_o,
  input  logic           mem_gnt_i,
  output logic           mem_we_o,
  output dc_pkg::addr_t  mem_addr_o,
  output mem_pkg::word_t mem_wdata_o,
  output mem_pkg::be_t   mem_be_o,
  input  logic           mem_rvalid_i,
  input  mem_pkg::word_t mem_rdata_i
);

  logic           cache_en;
  logic           inval_all;
  logic           ld_busy;
  dc_pkg::index_t lookup_idx;
  dc_pkg::line_t  lookup_line;

  dc_port_if  ld_miss_if ();
  dc_port_if  st_mem_if ();
  cache_wr_if refill_if ();
  cache_wr_if store_upd_if ();

  dc_mem u_mem (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .lookup_idx_i  (lookup_idx),
    .lookup_line_o (lookup_line),
    .refill        (refill_if),
    .store_upd     (store_upd_if),
    .inval_all_i   (inval_all)
  );

  dc_load_ctrl u_load_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .ld_req_i      (ld_req_i),
    .ld_addr_i     (ld_addr_i),
    .ld_gnt_o      (ld_gnt_o),
    .ld_rvalid_o   (ld_rvalid_o),
    .ld_rdata_o    (ld_rdata_o),
    .cache_en_i    (cache_en),
    .lookup_idx_o  (lookup_idx),
    .lookup_line_i (lookup_line),
    .miss_o        (miss_o),
    .miss          (ld_miss_if),
    .busy_o        (ld_busy)
  );

  dc_wbuffer u_wbuffer (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .st_req_i   (st_req_i),
    .st_addr_i  (st_addr_i),
    .st_wdata_i (st_wdata_i),
    .st_be_i    (st_be_i),
    .st_gnt_o   (st_gnt_o),
    .store_upd  (store_upd_if),
    .mem        (st_mem_if),
    .empty_o    (wbuffer_empty_o)
  );

  dc_miss_unit u_miss_unit (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .enable_i     (enable_i),
    .flush_i      (flush_i),
    .flush_ack_o  (flush_ack_o),
    .cache_en_o   (cache_en),
    .ld           (ld_miss_if),
    .st           (st_mem_if),
    .wbuf_empty_i (wbuffer_empty_o),
    .ld_busy_i    (ld_busy),
    .refill       (refill_if),
    .inval_all_o  (inval_all),
    .mem_req_o    (mem_req_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_be_o     (mem_be_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

endmodule

// File: test/tb_wt_dcache.sv
// testbench for the write-through L1 data cache
// table of loads, stores, flushes and enable changes against a memory model

`timescale 1ns/1ns

module tb_wt_dcache;

  typedef enum logic [1:0] {OP_LOAD, OP_STORE, OP_FLUSH, OP_ENABLE} op_e;

  typedef struct packed {
    op_e            op;
    dc_pkg::addr_t  addr;
    mem_pkg::word_t data;
    mem_pkg::be_t   be;
    mem_pkg::word_t exp;
    logic           exp_miss;
  } row_t;

  // A and B share index 4 with different tags
  localparam dc_pkg::addr_t ADDR_A = 32'h0000_0010;
  localparam dc_pkg::addr_t ADDR_B = 32'h0000_0050;
  localparam dc_pkg::addr_t ADDR_C = 32'h0000_0024;
  localparam dc_pkg::addr_t ADDR_D = 32'h0000_0030;

  logic           clk = 1'b0;
  logic           arst_n;
  logic           enable;
  logic           flush;
  logic           flush_ack;
  logic           miss;
  logic           wbuf_empty;
  logic           ld_req;
  logic           ld_gnt;
  dc_pkg::addr_t  ld_addr;
  logic           ld_rvalid;
  mem_pkg::word_t ld_rdata;
  logic           st_req;
  logic           st_gnt;
  dc_pkg::addr_t  st_addr;
  mem_pkg::word_t st_wdata;
  mem_pkg::be_t   st_be;
  logic           mem_req;
  logic           mem_gnt;
  logic           mem_we;
  dc_pkg::addr_t  mem_addr;
  mem_pkg::word_t mem_wdata;
  mem_pkg::be_t   mem_be;
  logic           mem_rvalid;
  mem_pkg::word_t mem_rdata;

  row_t           rows[$];
  logic [67:0]    exp_wr[$];
  mem_pkg::word_t mem_words [256];
  logic [31:0]    lfsr_q = 32'hafb0_7a77;
  dc_pkg::addr_t  rd_addr;
  int unsigned    rd_cnt;
  int unsigned    rd_count;
  int unsigned    cycle_q;
  int unsigned    miss_cnt;
  int unsigned    ack_cnt;
  int unsigned    err_cnt;
  int unsigned    bad_rows;

  always #20 clk = ~clk;

  wt_dcache dut_i (
    .clk_i (clk), .arst_n_i (arst_n), .enable_i (enable), .flush_i (flush),
    .flush_ack_o (flush_ack), .miss_o (miss), .wbuffer_empty_o (wbuf_empty),
    .ld_req_i (ld_req), .ld_gnt_o (ld_gnt), .ld_addr_i (ld_addr),
    .ld_rvalid_o (ld_rvalid), .ld_rdata_o (ld_rdata),
    .st_req_i (st_req), .st_gnt_o (st_gnt), .st_addr_i (st_addr),
    .st_wdata_i (st_wdata), .st_be_i (st_be),
    .mem_req_o (mem_req), .mem_gnt_i (mem_gnt), .mem_we_o (mem_we),
    .mem_addr_o (mem_addr), .mem_wdata_o (mem_wdata), .mem_be_o (mem_be),
    .mem_rvalid_i (mem_rvalid), .mem_rdata_i (mem_rdata)
  );

  // fill word of the memory model, built from the byte address
  function automatic mem_pkg::word_t pattern(dc_pkg::addr_t a);
    return {~a[15:0], a[15:0]};
  endfunction

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [3:0] rand_bits(int n);
    logic [3:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[2:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  function automatic void add_row(op_e op, dc_pkg::addr_t addr, mem_pkg::word_t data,
                                  mem_pkg::be_t be, mem_pkg::word_t exp, logic exp_miss);
    rows.push_back('{op, addr, data, be, exp, exp_miss});
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  function automatic void build_table();
    add_row(OP_LOAD,   ADDR_A, '0, '0, pattern(ADDR_A), 1'b1);
    add_row(OP_LOAD,   ADDR_A, '0, '0, pattern(ADDR_A), 1'b0);
    add_row(OP_STORE,  ADDR_A, 32'h1234_5678, 4'b0011, '0, 1'b0);
    add_row(OP_LOAD,   ADDR_A, '0, '0, 32'hffef_5678, 1'b0);
    // uncached store, the miss read sees it in memory
    add_row(OP_STORE,  ADDR_C, 32'hcafe_babe, 4'b1111, '0, 1'b0);
    add_row(OP_LOAD,   ADDR_C, '0, '0, 32'hcafe_babe, 1'b1);
    add_row(OP_LOAD,   ADDR_B, '0, '0, pattern(ADDR_B), 1'b1);
    add_row(OP_LOAD,   ADDR_A, '0, '0, 32'hffef_5678, 1'b1);
    // cache off, no refill
    add_row(OP_ENABLE, '0, 32'h0, '0, '0, 1'b0);
    add_row(OP_LOAD,   ADDR_D, '0, '0, pattern(ADDR_D), 1'b1);
    add_row(OP_LOAD,   ADDR_D, '0, '0, pattern(ADDR_D), 1'b1);
    add_row(OP_ENABLE, '0, 32'h1, '0, '0, 1'b0);
    add_row(OP_LOAD,   ADDR_D, '0, '0, pattern(ADDR_D), 1'b1);
    add_row(OP_LOAD,   ADDR_D, '0, '0, pattern(ADDR_D), 1'b0);
    // stores queued ahead of a flush
    add_row(OP_STORE,  ADDR_D, 32'h0bad_f00d, 4'b1100, '0, 1'b0);
    add_row(OP_STORE,  ADDR_A, 32'h5500_0000, 4'b1000, '0, 1'b0);
    add_row(OP_STORE,  ADDR_C, 32'h0000_0011, 4'b0001, '0, 1'b0);
    add_row(OP_FLUSH,  '0, '0, '0, '0, 1'b0);
    add_row(OP_LOAD,   ADDR_D, '0, '0, 32'h0bad_0030, 1'b1);
    add_row(OP_LOAD,   ADDR_A, '0, '0, 32'h55ef_5678, 1'b1);
    add_row(OP_LOAD,   ADDR_C, '0, '0, 32'hcafe_ba11, 1'b1);
    add_row(OP_LOAD,   ADDR_C, '0, '0, 32'hcafe_ba11, 1'b0);
  endfunction

  ////////////////////////////////////////////////////////////
  // memory model and monitors
  ////////////////////////////////////////////////////////////

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem_words[i] = pattern(i * 4);
    end
  end

  always @(posedge clk) begin
    logic [67:0] wr;
    if (arst_n && mem_req && mem_gnt) begin
      if (mem_we) begin
        assert (exp_wr.size() != 0) else begin
          $display("memory write to %h at %0t ns with no store pending", mem_addr, $time);
          err_cnt++;
        end
        if (exp_wr.size() != 0) begin
          wr = exp_wr.pop_front();
          check_word("mem_addr_o", mem_addr, wr[67:36]);
          check_word("mem_wdata_o", mem_wdata, wr[35:4]);
          check_word("mem_be_o", {28'h0, mem_be}, {28'h0, wr[3:0]});
        end
        for (int b = 0; b < 4; b++) begin
          if (mem_be[b]) begin
            mem_words[mem_addr[9:2]][8*b +: 8] = mem_wdata[8*b +: 8];
          end
        end
      end else begin
        rd_addr = mem_addr;
        rd_cnt = 1 + rand_bits(2);
        rd_count <= rd_count + 1;
      end
    end
    #2;
    mem_rvalid = 1'b0;
    if (rd_cnt != 0) begin
      rd_cnt--;
      if (rd_cnt == 0) begin
        mem_rvalid = 1'b1;
        mem_rdata  = mem_words[rd_addr[9:2]];
      end
    end
    mem_gnt = (rand_bits(2) != 0);
  end

  always @(posedge clk) begin
    cycle_q <= cycle_q + 1;
    if (miss) begin
      miss_cnt <= miss_cnt + 1;
    end
    if (flush_ack) begin
      ack_cnt <= ack_cnt + 1;
      assert (wbuf_empty) else begin
        $display("flush acknowledged at %0t ns with stores still buffered", $time);
        err_cnt++;
      end
    end
  end

  initial begin
    @(posedge arst_n);
    repeat (rows.size() * 200) @(posedge clk);
    $display("timeout: the table did not finish within %0d cycles", rows.size() * 200);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // row tasks, entered and left 2 ns after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic load_word(row_t r);
    int unsigned misses;
    int unsigned reads;
    int unsigned gnt_cyc;
    logic        saw_miss;
    misses  = miss_cnt;
    reads   = rd_count;
    ld_req  = 1'b1;
    ld_addr = r.addr;
    @(posedge clk);
    while (!ld_gnt) @(posedge clk);
    gnt_cyc = cycle_q;
    #2 ld_req = 1'b0;
    @(posedge clk);
    while (!ld_rvalid) @(posedge clk);
    saw_miss = (miss_cnt != misses);
    check_word("ld_rdata_o", ld_rdata, r.exp);
    assert (saw_miss == r.exp_miss) else begin
      $display("load of %h at %0t ns: expected a %s but the cache gave a %s", r.addr, $time,
               r.exp_miss ? "miss" : "hit", saw_miss ? "miss" : "hit");
      err_cnt++;
    end
    if (!r.exp_miss) begin
      assert (cycle_q == gnt_cyc + 1 && rd_count == reads) else begin
        $display("hit on %h at %0t ns was late or read memory", r.addr, $time);
        err_cnt++;
      end
    end
    #2;
  endtask

  task automatic store_word(row_t r);
    st_req   = 1'b1;
    st_addr  = r.addr;
    st_wdata = r.data;
    st_be    = r.be;
    @(posedge clk);
    while (!st_gnt) @(posedge clk);
    exp_wr.push_back({r.addr, r.data, r.be});
    #2 st_req = 1'b0;
  endtask

  // flush stays high one cycle past the acknowledge, which must not repeat
  task automatic flush_cache();
    int unsigned acks;
    acks  = ack_cnt;
    flush = 1'b1;
    @(posedge clk);
    while (!flush_ack) @(posedge clk);
    @(posedge clk);
    #2 flush = 1'b0;
    repeat (2) @(posedge clk);
    assert (ack_cnt == acks + 1) else begin
      $display("flush at %0t ns gave %0d acknowledge pulses", $time, ack_cnt - acks);
      err_cnt++;
    end
    #2;
  endtask

  task automatic set_enable(row_t r);
    enable = r.data[0];
    repeat (2) @(posedge clk);
    #2;
  endtask

  initial begin
    int unsigned errs;
    arst_n = 1'b0;
    enable = 1'b1;
    flush  = 1'b0;
    ld_req = 1'b0;
    ld_addr = '0;
    st_req = 1'b0;
    st_addr = '0;
    st_wdata = '0;
    st_be = '0;
    mem_gnt = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata = '0;
    build_table();
    repeat (3) @(posedge clk);
    check_word("ld_gnt_o", {31'h0, ld_gnt}, 32'h0);
    check_word("ld_rvalid_o", {31'h0, ld_rvalid}, 32'h0);
    check_word("mem_req_o", {31'h0, mem_req}, 32'h0);
    check_word("miss_o", {31'h0, miss}, 32'h0);
    check_word("flush_ack_o", {31'h0, flush_ack}, 32'h0);
    check_word("wbuffer_empty_o", {31'h0, wbuf_empty}, 32'h1);
    #2 arst_n = 1'b1;
    @(posedge clk);
    #2;
    foreach (rows[i]) begin
      errs = err_cnt;
      case (rows[i].op)
        OP_LOAD:   load_word(rows[i]);
        OP_STORE:  store_word(rows[i]);
        OP_FLUSH:  flush_cache();
        default:   set_enable(rows[i]);
      endcase
      if (err_cnt == errs) begin
        $display("row %0d %s ok", i, rows[i].op.name());
      end else begin
        $display("row %0d %s with %0d errors", i, rows[i].op.name(), err_cnt - errs);
        bad_rows++;
      end
    end
    assert (exp_wr.size() == 0) else begin
      $display("%0d stores never reached memory", exp_wr.size());
      err_cnt++;
    end
    $display("rows: %0d, rows with errors: %0d, errors: %0d", rows.size(), bad_rows, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+src
src/dc_pkg.sv
src/mem_pkg.sv
src/dc_port_if.sv
src/cache_wr_if.sv
src/dc_mem.sv
src/dc_load_ctrl.sv
src/dc_wbuffer.sv
src/dc_miss_unit.sv
src/wt_dcache.sv
test/tb_wt_dcache.sv
